// File: source/flash_pkg.sv
// flash update shared definitions
// EPCS serial flash opcodes, page and sector geometry, status register bits
package flash_pkg;

	// --------------------------------------------------
	// EPCS command set, only what the update path needs
	// --------------------------------------------------
	localparam logic [7:0] op_wren = 8'h06;	// write enable, required before se / pp
	localparam logic [7:0] op_rdsr = 8'h05;	// read status register
	localparam logic [7:0] op_se   = 8'hD8;	// sector erase, 64 KB
	localparam logic [7:0] op_pp   = 8'h02;	// page program, up to 256 bytes

	// --------------------------------------------------
	// geometry
	// --------------------------------------------------
	localparam int page_bytes   = 256;	// one program command
	localparam int sector_bytes = 65536;	// erase stride
	localparam int addr_w       = 24;	// three address bytes on the wire

	// status register
	localparam int sr_wip = 0;	// write in progress, set while erase / program runs

endpackage

// File: source/rx_byte_fifo.sv
// receive byte FIFO
// holds configuration bytes from the host stream until the update
// controller has a full flash page to move into the page engine
module rx_byte_fifo #(
	parameter int fifo_depth = 512	// power of two
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        wr_en,
	input  logic [7:0]                  wr_data,
	output logic                        full,
	input  logic                        rd_en,
	output logic [7:0]                  rd_data,
	output logic [$clog2(fifo_depth):0] level
);

	localparam int ptr_w = $clog2(fifo_depth);

	logic [7:0]       mem [fifo_depth];	// circular byte store
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             push;
	logic             pop;

	// level only reaches fifo_depth with its top bit set
	assign full = level[ptr_w];
	assign push = wr_en && !full;	// writes while full are dropped
	assign pop  = rd_en && (level != '0);	// reads while empty are dropped

	// --------------------------------------------------
	// pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;	// idle or push and pop together
			endcase
		end
	end

	// storage, read data registered so it lands one cycle after rd_en
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= wr_data;
		if (pop)
			rd_data <= mem[rd_ptr];
	end

endmodule

// File: source/asmi_page_engine.sv
// ASMI page engine
// drives an EPCS serial flash, mode 0, MSB first on a divided clock
// erase and program both send write enable, then the command with its
// three address bytes (plus the 256 byte page for a program), then poll
// the status register until the write in progress bit clears
module asmi_page_engine #(
	parameter int sck_div = 2	// system clocks per half period of flash_sck
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        cmd_erase,
	input  logic                        cmd_program,
	input  logic [flash_pkg::addr_w-1:0] cmd_addr,
	input  logic                        buf_wr,
	input  logic [7:0]                  buf_data,
	output logic                        busy,
	output logic                        flash_sck,
	output logic                        flash_cs_n,
	output logic                        flash_mosi,
	input  logic                        flash_miso
);

	localparam int              div_w    = $clog2(sck_div + 1);
	localparam logic [div_w-1:0] div_last = div_w'(sck_div - 1);

	typedef enum logic [3:0] {
		s_idle, s_wren, s_gap1, s_op, s_addr, s_data, s_gap2, s_rdsr, s_stat, s_gap3
	} seq_t;

	seq_t                        seq, seq_nxt;
	logic [7:0]                  page_buf [flash_pkg::page_bytes];
	logic [7:0]                  wr_idx;	// page buffer fill index
	logic [7:0]                  byte_idx;	// address or payload byte on the wire
	logic [flash_pkg::addr_w-1:0] addr_q;
	logic                        is_pp;	// 1 program, 0 sector erase
	logic [div_w-1:0]            div_cnt;
	logic                        tick;	// one half sck period elapsed
	logic                        sck;
	logic                        sh_act;	// shifter running, also chip select
	logic [7:0]                  sh_reg;
	logic [7:0]                  rx_reg;
	logic [2:0]                  bit_cnt;
	logic                        byte_end;
	logic                        launch;	// load a new byte into the shifter
	logic [7:0]                  tx_byte;

	assign tick       = (div_cnt == div_last);
	assign byte_end   = sh_act && tick && sck && (bit_cnt == 3'd7);	// last falling edge
	assign busy       = (seq != s_idle) || cmd_erase || cmd_program;
	assign flash_sck  = sck;
	assign flash_cs_n = ~sh_act;
	assign flash_mosi = sh_reg[7];

	// --------------------------------------------------
	// command sequencer
	// --------------------------------------------------
	always_comb begin
		seq_nxt = seq;
		launch  = 1'b0;
		tx_byte = 8'h00;
		case (seq)
			s_idle: if (cmd_erase || cmd_program) begin
				seq_nxt = s_wren;
				launch  = 1'b1;
				tx_byte = flash_pkg::op_wren;
			end
			s_wren: if (byte_end) seq_nxt = s_gap1;	// cs must rise to latch wren
			s_gap1: if (tick) begin
				seq_nxt = s_op;
				launch  = 1'b1;
				tx_byte = is_pp ? flash_pkg::op_pp : flash_pkg::op_se;
			end
			s_op: if (byte_end) begin
				seq_nxt = s_addr;
				launch  = 1'b1;
				tx_byte = addr_q[23:16];
			end
			s_addr: if (byte_end) begin
				launch = 1'b1;
				case (byte_idx)
					8'd0: tx_byte = addr_q[15:8];
					8'd1: tx_byte = addr_q[7:0];
					default: begin
						if (is_pp) begin
							seq_nxt = s_data;
							tx_byte = page_buf[0];
						end else begin
							seq_nxt = s_gap2;	// erase has no payload
							launch  = 1'b0;
						end
					end
				endcase
			end
			s_data: if (byte_end) begin
				if (byte_idx == 8'hff) begin
					seq_nxt = s_gap2;
				end else begin
					launch  = 1'b1;
					tx_byte = page_buf[byte_idx + 8'd1];
				end
			end
			s_gap2: if (tick) begin
				seq_nxt = s_rdsr;
				launch  = 1'b1;
				tx_byte = flash_pkg::op_rdsr;
			end
			s_rdsr: if (byte_end) begin
				seq_nxt = s_stat;
				launch  = 1'b1;	// dummy byte clocks the status in
			end
			s_stat: if (byte_end) seq_nxt = s_gap3;
			s_gap3: if (tick) begin
				if (rx_reg[flash_pkg::sr_wip]) begin
					seq_nxt = s_rdsr;	// still writing, poll again
					launch  = 1'b1;
					tx_byte = flash_pkg::op_rdsr;
				end else begin
					seq_nxt = s_idle;
				end
			end
			default: seq_nxt = s_idle;
		endcase
	end

	// --------------------------------------------------
	// sequencer state, serial clock and shifter
	// --------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			seq      <= s_idle;
			div_cnt  <= '0;
			sck      <= 1'b0;
			sh_act   <= 1'b0;
			sh_reg   <= '0;
			bit_cnt  <= '0;
			byte_idx <= '0;
			addr_q   <= '0;
			is_pp    <= 1'b0;
			wr_idx   <= '0;
		end else begin
			seq     <= seq_nxt;
			div_cnt <= (tick || launch) ? '0 : div_cnt + 1'b1;	// realign on a new byte
			if (seq == s_idle && (cmd_erase || cmd_program)) begin
				addr_q <= cmd_addr;
				is_pp  <= cmd_program;
			end
			if (tick && sh_act)
				sck <= ~sck;
			if (launch) begin
				sh_act   <= 1'b1;
				sh_reg   <= tx_byte;
				bit_cnt  <= '0;
				byte_idx <= (seq_nxt != seq) ? 8'd0 : byte_idx + 8'd1;
			end else if (byte_end) begin
				sh_act <= 1'b0;	// deselect after the last bit
			end else if (sh_act && tick && sck) begin
				sh_reg  <= {sh_reg[6:0], 1'b0};	// next bit out on the falling edge
				bit_cnt <= bit_cnt + 3'd1;
			end
			if (cmd_program)
				wr_idx <= '0;
			else if (buf_wr)
				wr_idx <= wr_idx + 8'd1;
		end
	end

	// page buffer and receive shift
	always_ff @(posedge clock) begin
		if (buf_wr)
			page_buf[wr_idx] <= buf_data;
		if (sh_act && tick && !sck)
			rx_reg <= {rx_reg[6:0], flash_miso};	// sample on the rising edge
	end

endmodule

// File: source/flash_update_ctrl.sv
// flash update controller
// erases the image sectors on request, then moves the host image into
// the page engine one 256 byte page at a time, bit reversed per byte,
// asks for more after every page and reloads the FPGA when done
module flash_update_ctrl #(
	parameter logic [flash_pkg::addr_w-1:0] start_addr    = 24'h100000,
	parameter logic [flash_pkg::addr_w-1:0] last_sector   = 24'h1F0000,
	parameter int                           reset_delay_w = 22,
	parameter int                           level_w       = 10	// FIFO level width
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        erase,
	output logic                        erase_ack,
	output logic                        erase_done,
	input  logic                        erase_done_ack,
	output logic                        send_more,
	input  logic                        send_more_ack,
	input  logic [13:0]                 num_blocks,
	input  logic [level_w-1:0]          fifo_level,
	output logic                        fifo_rd,
	input  logic [7:0]                  fifo_data,
	output logic                        cmd_erase,
	output logic                        cmd_program,
	output logic [flash_pkg::addr_w-1:0] cmd_addr,
	output logic                        buf_wr,
	output logic [7:0]                  buf_data,
	input  logic                        busy,
	output logic                        nconfig
);

	localparam int                aw          = flash_pkg::addr_w;
	localparam logic [aw-1:0]     sector_step = aw'(flash_pkg::sector_bytes);
	localparam logic [aw-1:0]     page_step   = aw'(flash_pkg::page_bytes);
	localparam logic [level_w-1:0] page_lvl   = level_w'(flash_pkg::page_bytes);

	typedef enum logic [3:0] {
		st_idle,
		st_erase_issue,
		st_erase_wait,
		st_erase_done,
		st_done_hs,
		st_fill,
		st_program,
		st_page_wait,
		st_final_ack,
		st_reconfig
	} state_t;

	state_t                   state;
	logic [aw-1:0]            address;	// current sector or page
	logic [13:0]              page;	// pages handed to the engine
	logic [8:0]               byte_count;	// FIFO pops issued for this page
	logic [reset_delay_w-1:0] reset_delay;	// lets the host see the final send_more
	logic                     page_ready;

	assign page_ready  = (fifo_level >= page_lvl);
	assign fifo_rd     = (state == st_fill) && !byte_count[8];	// 256 pops, one per cycle
	assign cmd_erase   = (state == st_erase_issue);
	assign cmd_program = (state == st_program);
	assign cmd_addr    = address;
	assign buf_data    = {<<{fifo_data}};	// configuration format wants LSB first

	// --------------------------------------------------
	// main state machine
	// --------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state       <= st_idle;
			address     <= start_addr;
			page        <= '0;
			byte_count  <= '0;
			reset_delay <= '0;
			erase_ack   <= 1'b0;
			erase_done  <= 1'b0;
			send_more   <= 1'b0;
			buf_wr      <= 1'b0;
			nconfig     <= 1'b0;
		end else begin
			buf_wr <= fifo_rd;	// FIFO data arrives a cycle after the pop
			case (state)
				st_idle: begin
					address    <= start_addr;
					page       <= '0;
					byte_count <= '0;
					if (erase) begin
						erase_ack <= 1'b1;	// host drops erase on this
						state     <= st_erase_issue;
					end else if (page_ready && !busy && !send_more) begin
						state <= st_fill;
					end
				end
				// erase, one sector per pass
				st_erase_issue: state <= st_erase_wait;
				st_erase_wait: if (!busy) begin
					if (address != last_sector) begin
						address <= address + sector_step;
						state   <= st_erase_issue;
					end else begin
						state <= st_erase_done;
					end
				end
				st_erase_done: begin
					erase_done <= 1'b1;
					state      <= st_done_hs;
				end
				st_done_hs: if (erase_done_ack) begin
					erase_done <= 1'b0;
					erase_ack  <= 1'b0;
					state      <= st_idle;
				end
				// program path
				st_fill: begin
					if (!byte_count[8])
						byte_count <= byte_count + 9'd1;
					else
						state <= st_program;	// final buffer write lands this cycle
				end
				st_program: begin
					page      <= page + 14'd1;
					send_more <= 1'b1;	// page is with the engine, ask for the next
					state     <= st_page_wait;
				end
				st_page_wait: begin
					if (send_more_ack)
						send_more <= 1'b0;
					if (!send_more && !send_more_ack) begin
						if (page == num_blocks) begin
							send_more <= 1'b1;	// final request, marks the image complete
							state     <= st_final_ack;
						end else if (!busy && page_ready) begin
							address    <= address + page_step;
							byte_count <= '0;
							state      <= st_fill;
						end
					end
				end
				st_final_ack: if (send_more_ack) begin
					send_more <= 1'b0;
					state     <= st_reconfig;
				end
				// hold off, then reload once the last page is in flash
				st_reconfig: begin
					if (&reset_delay) begin
						if (!busy)
							nconfig <= 1'b1;
					end else begin
						reset_delay <= reset_delay + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: source/flash_update_top.sv
// flash update top level
// host byte stream into the receive FIFO, update controller in the middle,
// ASMI page engine out to the serial configuration flash
module flash_update_top #(
	parameter logic [flash_pkg::addr_w-1:0] start_addr    = 24'h100000,
	parameter logic [flash_pkg::addr_w-1:0] last_sector   = 24'h1F0000,
	parameter int                           fifo_depth    = 512,
	parameter int                           reset_delay_w = 22,
	parameter int                           sck_div       = 2
) (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        rx_valid,
	input  logic [7:0]  rx_data,
	output logic        rx_ready,
	input  logic        erase,
	output logic        erase_ack,
	output logic        erase_done,
	input  logic        erase_done_ack,
	output logic        send_more,
	input  logic        send_more_ack,
	input  logic [13:0] num_blocks,
	output logic        nconfig,
	output logic        flash_sck,
	output logic        flash_cs_n,
	output logic        flash_mosi,
	input  logic        flash_miso
);

	localparam int level_w = $clog2(fifo_depth) + 1;

	logic                        fifo_full;
	logic                        fifo_rd;
	logic [7:0]                  fifo_data;
	logic [level_w-1:0]          fifo_level;
	logic                        cmd_erase;
	logic                        cmd_program;
	logic [flash_pkg::addr_w-1:0] cmd_addr;
	logic                        buf_wr;
	logic [7:0]                  buf_data;
	logic                        busy;

	assign rx_ready = ~fifo_full;	// host holds its byte while full

	// --------------------------------------------------
	// host side buffer
	// --------------------------------------------------
	rx_byte_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.clock  (clock),
		.arst_n (arst_n),
		.wr_en  (rx_valid),
		.wr_data(rx_data),
		.full   (fifo_full),
		.rd_en  (fifo_rd),
		.rd_data(fifo_data),
		.level  (fifo_level)
	);

	flash_update_ctrl #(
		.start_addr   (start_addr),
		.last_sector  (last_sector),
		.reset_delay_w(reset_delay_w),
		.level_w      (level_w)
	) u_ctrl (
		.clock         (clock),
		.arst_n        (arst_n),
		.erase         (erase),
		.erase_ack     (erase_ack),
		.erase_done    (erase_done),
		.erase_done_ack(erase_done_ack),
		.send_more     (send_more),
		.send_more_ack (send_more_ack),
		.num_blocks    (num_blocks),
		.fifo_level    (fifo_level),
		.fifo_rd       (fifo_rd),
		.fifo_data     (fifo_data),
		.cmd_erase     (cmd_erase),
		.cmd_program   (cmd_program),
		.cmd_addr      (cmd_addr),
		.buf_wr        (buf_wr),
		.buf_data      (buf_data),
		.busy          (busy),
		.nconfig       (nconfig)
	);

	// serial flash side
	asmi_page_engine #(
		.sck_div(sck_div)
	) u_engine (
		.clock      (clock),
		.arst_n     (arst_n),
		.cmd_erase  (cmd_erase),
		.cmd_program(cmd_program),
		.cmd_addr   (cmd_addr),
		.buf_wr     (buf_wr),
		.buf_data   (buf_data),
		.busy       (busy),
		.flash_sck  (flash_sck),
		.flash_cs_n (flash_cs_n),
		.flash_mosi (flash_mosi),
		.flash_miso (flash_miso)
	);

endmodule

// File: verif/epcs_model.sv
// EPCS serial flash model
// sparse byte memory where erased bytes read FFh, write in progress held
// for a fixed number of serial clocks, protocol misuse raises proto_err
module epcs_model #(
	parameter int erase_sck   = 96,	// serial clocks of busy after a sector erase
	parameter int program_sck = 40	// serial clocks of busy after a page program
) (
	input  logic sck,
	input  logic cs_n,
	input  logic mosi,
	output logic miso,
	output logic proto_err
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0]  mem [logic [23:0]];	// only written bytes are stored
	logic [7:0]  shift_in = 8'h00;
	logic [7:0]  opcode   = 8'h00;
	logic [23:0] addr     = '0;
	logic [7:0]  status;
	int          bits     = 0;	// bits clocked in since chip select fell
	int          wip_cnt  = 0;
	logic        wel      = 1'b0;	// write enable latch
	logic        wip;

	assign wip = (wip_cnt != 0);

	initial begin
		miso      = 1'b0;
		proto_err = 1'b0;
	end

	always @(negedge cs_n)
		bits = 0;

	// --------------------------------------------------
	// command, address and data bytes, sampled on rising sck
	// --------------------------------------------------
	always @(posedge sck) begin : shift_bit
		logic [23:0] a;
		if (!cs_n) begin
			shift_in = {shift_in[6:0], mosi};
			bits     = bits + 1;
			if (bits == 8) begin
				opcode = shift_in;
				if (wip && shift_in != flash_pkg::op_rdsr)
					proto_err = 1'b1;	// only status reads while writing
				if ((shift_in == flash_pkg::op_se || shift_in == flash_pkg::op_pp) && !wel)
					proto_err = 1'b1;	// missing write enable
			end else if (bits <= 32 && bits % 8 == 0 &&
				(opcode == flash_pkg::op_se || opcode == flash_pkg::op_pp)) begin
				addr = {addr[15:0], shift_in};
			end else if (bits >= 40 && bits % 8 == 0 && opcode == flash_pkg::op_pp) begin
				a = {addr[23:8], addr[7:0] + 8'((bits - 40) / 8)};	// page wrap
				if (mem.exists(a) && mem[a] != 8'hFF)
					proto_err = 1'b1;	// program over unerased byte
				mem[a] = shift_in;
			end
		end
		if (wip_cnt != 0)
			wip_cnt = wip_cnt - 1;
	end

	// status register out on falling sck, MSB first
	always @(negedge sck) begin
		status                   = 8'h00;
		status[flash_pkg::sr_wip] = wip;
		if (!cs_n && opcode == flash_pkg::op_rdsr && bits >= 8)
			miso = status[7 - ((bits - 8) % 8)];
	end

	// commands take effect when chip select rises
	always @(posedge cs_n) begin : end_of_command
		logic [23:0] base;
		base = {addr[23:16], 16'h0000};
		if (opcode == flash_pkg::op_wren && bits == 8) begin
			wel = 1'b1;
		end else if (opcode == flash_pkg::op_se) begin
			if (bits != 32) begin
				proto_err = 1'b1;	// truncated erase
			end else begin
				for (int i = 0; i < flash_pkg::sector_bytes; i++)
					if (mem.exists(base + 24'(i)))
						mem.delete(base + 24'(i));
			end
			wel     = 1'b0;
			wip_cnt = erase_sck;
		end else if (opcode == flash_pkg::op_pp) begin
			if (bits < 40 || bits % 8 != 0)
				proto_err = 1'b1;	// no payload or partial byte
			wel     = 1'b0;
			wip_cnt = program_sck;
		end
	end

	function automatic logic [7:0] read_byte(input logic [23:0] a);
		if (mem.exists(a))
			return mem[a];
		return 8'hFF;
	endfunction

	task automatic preload_byte(input logic [23:0] a, input logic [7:0] d);
		mem[a] = d;	// backdoor, no busy time
	endtask

endmodule

// File: verif/tb_flash_update.sv
// flash update testbench
// erases the image sectors, streams a three page image with random gaps
// and delayed acknowledges, then checks the flash image against a bit
// reversal reference, the page requests and the reconfigure output
module tb_flash_update;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [23:0] start_addr  = 24'h100000;
	localparam logic [23:0] last_sector = 24'h120000;
	localparam int          n_pages     = 3;
	localparam int          n_bytes     = n_pages * flash_pkg::page_bytes;
	localparam int          n_sectors   =
		int'((last_sector - start_addr) / flash_pkg::sector_bytes) + 1;
	localparam int          erase_sck   = 96;
	localparam int          program_sck = 40;
	localparam int          sck_sys     = 4;	// system clocks per serial clock at sck_div 2
	localparam int          erase_cyc   = (64 + erase_sck + 64) * sck_sys;
	localparam int          page_cyc    =
		(64 + 8 * flash_pkg::page_bytes + program_sck + 64) * sck_sys + 300;
	localparam int          cycle_limit =
		2 * (n_sectors * erase_cyc + n_pages * page_cyc + n_bytes * 5) + 2000;
	localparam int          probe_offs [6] = '{0, 255, 256, 4097, 32768, 65535};
	localparam logic [23:0] lo_guard    = start_addr - 24'd1;	// just below the range
	localparam logic [23:0] hi_guard    = last_sector + 24'(flash_pkg::sector_bytes);

	logic        clock;
	logic        arst_n;
	logic        rx_valid;
	logic [7:0]  rx_data;
	logic        rx_ready;
	logic        erase;
	logic        erase_ack;
	logic        erase_done;
	logic        erase_done_ack;
	logic        send_more;
	logic        send_more_ack;
	logic [13:0] num_blocks;
	logic        nconfig;
	logic        flash_sck;
	logic        flash_cs_n;
	logic        flash_mosi;
	logic        flash_miso;
	logic        proto_err;

	integer      seed;
	logic [7:0]  src [n_bytes];	// image as sent by the host
	logic [23:0] probe_q [$];	// addresses preloaded before the erase
	int          n_checks    = 0;
	int          n_errors    = 0;
	int          cycles      = 0;
	int          rise_count  = 0;	// rising edges of send_more
	int          page_errs   = 0;
	int          recfg_errs  = 0;
	int          mismatches  = 0;
	int          flow_errs   = 0;
	bit          final_acked = 1'b0;
	bit          nconfig_seen = 1'b0;
	bit          image_ready = 1'b0;
	bit          compare_finished = 1'b0;

	flash_update_top #(
		.last_sector  (last_sector),
		.reset_delay_w(6)
	) UUT (
		.clock(clock), .arst_n(arst_n),
		.rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
		.erase(erase), .erase_ack(erase_ack),
		.erase_done(erase_done), .erase_done_ack(erase_done_ack),
		.send_more(send_more), .send_more_ack(send_more_ack),
		.num_blocks(num_blocks), .nconfig(nconfig),
		.flash_sck(flash_sck), .flash_cs_n(flash_cs_n),
		.flash_mosi(flash_mosi), .flash_miso(flash_miso)
	);

	epcs_model #(
		.erase_sck  (erase_sck),
		.program_sck(program_sck)
	) flash (
		.sck(flash_sck), .cs_n(flash_cs_n), .mosi(flash_mosi),
		.miso(flash_miso), .proto_err(proto_err)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns period
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not complete within %0d clock cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// --------------------------------------------------
	// reference and helpers
	// --------------------------------------------------
	// configuration format stores every byte LSB first
	function automatic logic [7:0] expected_flash_byte(input int idx);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = src[idx][7 - i];
		return r;
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [23:0] a);
		return (a[23:16] ^ a[15:8] ^ a[7:0]) & 8'h7F;	// never FFh
	endfunction

	task automatic preload_sectors();
		logic [23:0] a;
		for (int s = 0; s < n_sectors; s++) begin
			for (int k = 0; k < 10; k++) begin
				a = start_addr + 24'(s * flash_pkg::sector_bytes);
				if (k < 6)
					a = a + 24'(probe_offs[k]);
				else
					a = a + 24'($random(seed) & 32'hFFFF);	// random spot in the sector
				probe_q.push_back(a);
				flash.preload_byte(a, fill_pattern(a));
			end
		end
		flash.preload_byte(lo_guard, fill_pattern(lo_guard));
		flash.preload_byte(hi_guard, fill_pattern(hi_guard));
	endtask

	task automatic check_erased();
		logic [7:0] got;
		foreach (probe_q[i]) begin
			got = flash.read_byte(probe_q[i]);
			n_checks++;
			if (got !== 8'hFF) begin
				$display("error at %0t ns: flash[%06h] expected ff actual %02h",
					$time, probe_q[i], got);
				n_errors++;
			end
		end
		got = flash.read_byte(lo_guard);
		n_checks++;
		if (got !== fill_pattern(lo_guard)) begin
			$display("error at %0t ns: flash[%06h] expected %02h actual %02h",
				$time, lo_guard, fill_pattern(lo_guard), got);
			n_errors++;
		end
		got = flash.read_byte(hi_guard);
		n_checks++;
		if (got !== fill_pattern(hi_guard)) begin
			$display("error at %0t ns: flash[%06h] expected %02h actual %02h",
				$time, hi_guard, fill_pattern(hi_guard), got);
			n_errors++;
		end
	endtask

	// --------------------------------------------------
	// page request responder, random acknowledge delay
	// --------------------------------------------------
	always begin : ack_responder
		int delay;
		@(posedge send_more);
		rise_count = rise_count + 1;
		delay = $random(seed) & 7;
		repeat (delay + 1) @(negedge clock);
		send_more_ack = 1'b1;
		@(negedge clock);
		send_more_ack = 1'b0;
		n_checks++;
		if (send_more !== 1'b0) begin
			$display("error at %0t ns: send_more expected 0 actual %b", $time, send_more);
			n_errors++;
			page_errs++;
		end
		if (rise_count == n_pages + 1)
			final_acked = 1'b1;	// last request handled, reload may follow
	end

	// nconfig stays low until the final acknowledge, then stays high
	always @(negedge clock) begin
		if (arst_n && nconfig === 1'b1 && !final_acked) begin
			$display("reconfigure failure at %0t ns: nconfig rose before the final acknowledge",
				$time);
			n_errors++;
			recfg_errs++;
		end
		if (nconfig_seen && nconfig !== 1'b1) begin
			$display("error at %0t ns: nconfig expected 1 actual %b", $time, nconfig);
			n_errors++;
			recfg_errs++;
		end
		if (nconfig === 1'b1)
			nconfig_seen = 1'b1;
	end

	// flash image against the reference once the FPGA reload is requested
	initial begin : compare_image
		logic [23:0] a;
		logic [7:0]  exp;
		logic [7:0]  got;
		wait (image_ready);
		for (int i = 0; i < n_bytes + 16; i++) begin
			a   = start_addr + 24'(i);
			exp = (i < n_bytes) ? expected_flash_byte(i) : 8'hFF;	// tail stays erased
			got = flash.read_byte(a);
			n_checks++;
			if (got !== exp) begin
				$display("error at %0t ns: flash[%06h] expected %02h actual %02h",
					$time, a, exp, got);
				n_errors++;
				mismatches++;
			end
		end
		$display("test 2 programming: %0d bytes compared, %0d mismatches",
			n_bytes + 16, mismatches);
		compare_finished = 1'b1;
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin : main
		int gap;
		int errs_before;
		seed           = 32'h28a5_4850;
		arst_n         = 1'b0;
		rx_valid       = 1'b0;
		rx_data        = 8'h00;
		erase          = 1'b0;
		erase_done_ack = 1'b0;
		send_more_ack  = 1'b0;
		num_blocks     = 14'(n_pages);
		for (int i = 0; i < n_bytes; i++)
			src[i] = 8'($random(seed));
		preload_sectors();
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		// test 1, erase handshake and sector contents
		errs_before = n_errors;
		erase = 1'b1;
		@(negedge clock);	// idle sees the request on the edge just passed
		n_checks++;
		if (erase_ack !== 1'b1) begin
			$display("error at %0t ns: erase_ack expected 1 actual %b", $time, erase_ack);
			n_errors++;
		end
		n_checks++;
		if (erase_done !== 1'b0) begin
			$display("error at %0t ns: erase_done expected 0 actual %b", $time, erase_done);
			n_errors++;
		end
		erase = 1'b0;	// host drops the request on the acknowledge
		while (erase_done !== 1'b1) @(negedge clock);
		check_erased();
		erase_done_ack = 1'b1;
		@(negedge clock);
		erase_done_ack = 1'b0;
		n_checks++;
		if (erase_done !== 1'b0) begin
			$display("error at %0t ns: erase_done expected 0 actual %b", $time, erase_done);
			n_errors++;
		end
		n_checks++;
		if (erase_ack !== 1'b0) begin
			$display("error at %0t ns: erase_ack expected 0 actual %b", $time, erase_ack);
			n_errors++;
		end
		$display("test 1 erase: %0d errors", n_errors - errs_before);

		// image stream, host holds each byte while rx_ready is low
		for (int i = 0; i < n_bytes; i++) begin
			gap = $random(seed) & 3;
			if (gap != 0) begin
				rx_valid = 1'b0;
				repeat (gap) @(negedge clock);
			end
			rx_valid = 1'b1;
			rx_data  = src[i];
			while (rx_ready !== 1'b1) @(negedge clock);
			@(negedge clock);	// taken on the rising edge just passed
		end
		rx_valid = 1'b0;

		// first page is still programming, the other two fill the 512 byte FIFO
		n_checks++;
		if (rx_ready !== 1'b0) begin
			$display("error at %0t ns: rx_ready expected 0 actual %b", $time, rx_ready);
			n_errors++;
			flow_errs++;
		end

		while (nconfig !== 1'b1) @(negedge clock);
		repeat (20) @(negedge clock);	// nconfig monitor keeps watching
		image_ready = 1'b1;
		wait (compare_finished);

		// test 3, one request per page plus the final one
		n_checks++;
		if (rise_count != n_pages + 1) begin
			$display("error at %0t ns: send_more rises expected %0d actual %0d",
				$time, n_pages + 1, rise_count);
			n_errors++;
			page_errs++;
		end
		$display("test 3 page requests: %0d rises, %0d errors", rise_count, page_errs);

		// test 4, gaps and late acknowledges left the image and protocol intact
		n_checks++;
		if (proto_err !== 1'b0) begin
			$display("protocol failure at %0t ns: the flash model saw a bad command sequence",
				$time);
			n_errors++;
		end
		$display("test 4 back-pressure: %0d mismatches, %0d flow errors, protocol error flag %b",
			mismatches, flow_errs, proto_err);
		$display("test 5 reconfigure: %0d errors", recfg_errs);

		$display("checks %0d, errors %0d, cycles %0d", n_checks, n_errors, cycles);
		if (n_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim.f
source/flash_pkg.sv
source/rx_byte_fifo.sv
source/asmi_page_engine.sv
source/flash_update_ctrl.sv
source/flash_update_top.sv
verif/epcs_model.sv
verif/tb_flash_update.sv

// File: Bender.yml
package:
  name: flash_update

sources:
  - source/flash_pkg.sv
  - source/rx_byte_fifo.sv
  - source/asmi_page_engine.sv
  - source/flash_update_ctrl.sv
  - source/flash_update_top.sv
  - target: simulation
    files:
      - verif/epcs_model.sv
      - verif/tb_flash_update.sv
